//--- verilog/tx_iq_config.svh
// width, gain, fifo depth and fuzzer scaling macros for the tx i/q path
`ifndef TX_IQ_CONFIG_SVH
`define TX_IQ_CONFIG_SVH

// bits per I or Q component, as seen by the DAC
`define TX_IQ_WIDTH 16

// baseband gain, signed
`define TX_BB_GAIN_WIDTH 10
`define TX_GAIN_SHIFT 7     // gain has 7 fractional bits

// channel-state fuzzer taps, signed
`define TX_FUZZ_WIDTH 6
`define TX_FUZZ_SHIFT 4     // tap products scaled down by 16

// sample fifo
`define TX_FIFO_DEPTH 512
`define TX_FIFO_CNT_WIDTH 10 // must hold TX_FIFO_DEPTH itself

`endif

//--- verilog/tx_iq_sample_pkg.sv
// datapath types: i/q component, packed i/q pair, baseband and fuzzer gains, fifo count
`include "tx_iq_config.svh"

package tx_iq_sample_pkg;

    // one I or Q component
    typedef logic signed [`TX_IQ_WIDTH-1:0] iq_t;

    // Q in the upper half, I in the lower half
    typedef struct packed {
        iq_t q;
        iq_t i;
    } iq_pair_t;

    // baseband gain, applied before the fifo
    typedef logic signed [`TX_BB_GAIN_WIDTH-1:0] bb_gain_t;

    // fuzzer tap coefficient
    typedef logic signed [`TX_FUZZ_WIDTH-1:0] fuzz_gain_t;

    // fifo occupancy, also the hold threshold
    typedef logic [`TX_FIFO_CNT_WIDTH-1:0] fifo_cnt_t;

endpackage

//--- verilog/tx_iq_ctrl_pkg.sv
// control enums: fifo source select, playback state, host write handshake state
package tx_iq_ctrl_pkg;

    // who fills the sample fifo
    typedef enum logic {
        src_core, // transmit core through the gain stage
        src_host  // host req/ack port, played back on trigger
    } iq_src_e;

    // arbitrary-mode playback
    typedef enum logic {
        play_idle,
        play_run
    } play_state_e;

    // four-phase host write
    typedef enum logic [1:0] {
        wr_idle,     // waiting for req
        wr_ack,      // sample taken, ack high until req drops
        wr_wait_low  // one turnaround cycle with ack low
    } host_wr_state_e;

endpackage

//--- verilog/tx_gain_stage.sv
// tx_gain_stage: baseband gain multiply and fifo write strobe for core samples
`include "tx_iq_config.svh"

module tx_gain_stage (
    input  logic                        clk,
    input  logic                        rstn,
    input  tx_iq_sample_pkg::iq_t       rf_i,
    input  tx_iq_sample_pkg::iq_t       rf_q,
    input  logic                        rf_iq_valid,
    input  tx_iq_sample_pkg::bb_gain_t  bb_gain,
    input  logic                        tx_hold,
    output tx_iq_sample_pkg::iq_pair_t  scaled_pair,
    output logic                        scaled_wr
);

    // full product width, no overflow possible
    localparam int PROD_W = `TX_IQ_WIDTH + `TX_BB_GAIN_WIDTH;
    localparam int LSB    = `TX_GAIN_SHIFT;
    localparam int MSB    = `TX_GAIN_SHIFT + `TX_IQ_WIDTH - 1;

    logic signed [PROD_W-1:0] prod_i;
    logic signed [PROD_W-1:0] prod_q;

    // products only matter when scaled_wr is high
    always_ff @(posedge clk) begin
        prod_i <= rf_i * bb_gain;
        prod_q <= rf_q * bb_gain;
    end

    // a sample offered while held is dropped, the core is expected to stall
    always_ff @(posedge clk) begin
        if (!rstn) begin
            scaled_wr <= 1'b0;
        end else begin
            scaled_wr <= rf_iq_valid && !tx_hold;
        end
    end

    // undo the gain's fractional bits, upper bits wrap off
    assign scaled_pair = {prod_q[MSB:LSB], prod_i[MSB:LSB]};

endmodule

//--- verilog/tx_iq_fifo.sv
// tx_iq_fifo: first-word-fall-through i/q sample fifo with occupancy count
`include "tx_iq_config.svh"

module tx_iq_fifo (
    input  logic                        clk,
    input  logic                        rstn,
    input  logic                        wr_en,
    input  tx_iq_sample_pkg::iq_pair_t  wr_data,
    input  logic                        rd_en,
    output tx_iq_sample_pkg::iq_pair_t  rd_data,
    output logic                        empty,
    output logic                        full,
    output tx_iq_sample_pkg::fifo_cnt_t count
);

    import tx_iq_sample_pkg::*;

    localparam int PTR_W = $clog2(`TX_FIFO_DEPTH);

    iq_pair_t           mem [`TX_FIFO_DEPTH];
    logic [PTR_W-1:0]   wr_ptr;
    logic [PTR_W-1:0]   rd_ptr;
    logic               do_wr;
    logic               do_rd;

    // overflow and underflow attempts are dropped
    assign do_wr = wr_en && !full;
    assign do_rd = rd_en && !empty;

    assign empty = (count == '0);
    assign full  = (count == fifo_cnt_t'(`TX_FIFO_DEPTH));

    assign rd_data = mem[rd_ptr]; // head shown without a read

    always_ff @(posedge clk) begin
        if (do_wr) begin
            mem[wr_ptr] <= wr_data;
        end
    end

    // pointers wrap at the power-of-two depth
    always_ff @(posedge clk) begin
        if (!rstn) begin
            wr_ptr <= '0;
            rd_ptr <= '0;
            count  <= '0;
        end else begin
            if (do_wr) begin
                wr_ptr <= wr_ptr + 1'b1;
            end
            if (do_rd) begin
                rd_ptr <= rd_ptr + 1'b1;
            end
            case ({do_wr, do_rd})
                2'b10:   count <= count + 1'b1;
                2'b01:   count <= count - 1'b1;
                default: count <= count; // both or neither
            endcase
        end
    end

endmodule

//--- verilog/tx_iq_intf.sv
// tx_iq_intf: fifo source mux, tx hold, host req/ack loading and triggered playback
module tx_iq_intf (
    input  logic                        clk,
    input  logic                        rstn,
    input  tx_iq_ctrl_pkg::iq_src_e     iq_src,
    input  tx_iq_sample_pkg::iq_pair_t  scaled_pair,
    input  logic                        scaled_wr,
    input  logic                        host_req,
    input  tx_iq_sample_pkg::iq_pair_t  host_data,
    output logic                        host_ack,
    input  logic                        play_trigger,
    input  logic                        dac_ready,
    input  tx_iq_sample_pkg::fifo_cnt_t tx_hold_threshold,
    output logic                        tx_hold,
    output logic                        fifo_empty,
    output tx_iq_sample_pkg::iq_pair_t  out_pair
);

    import tx_iq_sample_pkg::*;
    import tx_iq_ctrl_pkg::*;

    host_wr_state_e wr_state;
    play_state_e    play_state;
    logic           trig_d;      // previous trigger level
    logic           host_wr;
    logic           fifo_wr;
    logic           fifo_rd;
    logic           fifo_full;
    iq_pair_t       fifo_wr_data;
    iq_pair_t       fifo_head;
    fifo_cnt_t      fifo_count;

    // host sample accepted only when idle and there is room
    assign host_wr = (iq_src == src_host) && (wr_state == wr_idle) && host_req && !fifo_full;
    assign host_ack = (wr_state == wr_ack);

    always_ff @(posedge clk) begin
        if (!rstn) begin
            wr_state <= wr_idle;
        end else begin
            case (wr_state)
                wr_idle:     if (host_wr) wr_state <= wr_ack;
                wr_ack:      if (!host_req) wr_state <= wr_wait_low;
                wr_wait_low: wr_state <= wr_idle;
                default:     wr_state <= wr_idle;
            endcase
        end
    end

    // playback runs from a trigger edge until the fifo drains
    always_ff @(posedge clk) begin
        if (!rstn) begin
            trig_d     <= 1'b0;
            play_state <= play_idle;
        end else begin
            trig_d <= play_trigger;
            if (fifo_empty) begin
                play_state <= play_idle;
            end else if (iq_src == src_host && play_trigger && !trig_d) begin
                play_state <= play_run;
            end
        end
    end

    assign fifo_wr      = (iq_src == src_core) ? scaled_wr : host_wr;
    assign fifo_wr_data = (iq_src == src_core) ? scaled_pair : host_data;
    assign fifo_rd      = dac_ready && (iq_src == src_core || play_state == play_run);

    assign tx_hold = (fifo_count > tx_hold_threshold); // core stalls above threshold

    // zeros to the DAC when there is nothing to play
    always_comb begin
        out_pair = fifo_head;
        if (fifo_empty || (iq_src == src_host && play_state != play_run)) begin
            out_pair = '0;
        end
    end

    tx_iq_fifo tx_iq_fifo_i (
        .clk     (clk),
        .rstn    (rstn),
        .wr_en   (fifo_wr),
        .wr_data (fifo_wr_data),
        .rd_en   (fifo_rd),
        .rd_data (fifo_head),
        .empty   (fifo_empty),
        .full    (fifo_full),
        .count   (fifo_count)
    );

endmodule

//--- verilog/csi_fuzzer.sv
// csi_fuzzer: three-tap complex channel filter with 90-degree tap rotation
`include "tx_iq_config.svh"

module csi_fuzzer (
    input  logic                         clk,
    input  logic                         rstn,
    input  tx_iq_sample_pkg::iq_pair_t   iq,
    input  logic                         iq_valid,
    input  tx_iq_sample_pkg::fuzz_gain_t gain1,
    input  logic                         gain1_rot90,
    input  tx_iq_sample_pkg::fuzz_gain_t gain2,
    input  logic                         gain2_rot90,
    output tx_iq_sample_pkg::iq_pair_t   iq_out
);

    import tx_iq_sample_pkg::*;

    localparam int TAP_IN_W = `TX_IQ_WIDTH + 1;          // room for -q
    localparam int TAP_P_W  = TAP_IN_W + `TX_FUZZ_WIDTH;

    iq_pair_t                    x1;  // previous input
    iq_pair_t                    x2;  // the one before
    logic signed [TAP_IN_W-1:0]  t1_i;
    logic signed [TAP_IN_W-1:0]  t1_q;
    logic signed [TAP_IN_W-1:0]  t2_i;
    logic signed [TAP_IN_W-1:0]  t2_q;
    iq_t                         acc_i;
    iq_t                         acc_q;

    // exact product, scaled, wrapped to a component
    function automatic iq_t tap_term(input fuzz_gain_t g, input logic signed [TAP_IN_W-1:0] x);
        logic signed [TAP_P_W-1:0] p;
        p = g * x;
        return iq_t'(p >>> `TX_FUZZ_SHIFT);
    endfunction

    // rotation takes (i, q) to (-q, i)
    always_comb begin
        t1_i = gain1_rot90 ? -x1.q : x1.i;
        t1_q = gain1_rot90 ? x1.i : x1.q;
        t2_i = gain2_rot90 ? -x2.q : x2.i;
        t2_q = gain2_rot90 ? x2.i : x2.q;
    end

    // sums wrap at 16 bits
    assign acc_i = iq.i + tap_term(gain1, t1_i) + tap_term(gain2, t2_i);
    assign acc_q = iq.q + tap_term(gain1, t1_q) + tap_term(gain2, t2_q);

    // delay line and output step together, once per DAC request
    always_ff @(posedge clk) begin
        if (!rstn) begin
            x1     <= '0;
            x2     <= '0;
            iq_out <= '0;
        end else if (iq_valid) begin
            x1     <= iq;
            x2     <= x1;
            iq_out <= '{q: acc_q, i: acc_i};
        end
    end

endmodule

//--- verilog/tx_iq_top.sv
// tx_iq_top: gain stage, sample fifo interface and csi fuzzer between tx core and DAC
module tx_iq_top (
    input  logic                         clk,
    input  logic                         rstn,
    // transmit core
    input  tx_iq_sample_pkg::iq_t        rf_i,
    input  tx_iq_sample_pkg::iq_t        rf_q,
    input  logic                         rf_iq_valid,
    output logic                         tx_hold,
    input  tx_iq_sample_pkg::fifo_cnt_t  tx_hold_threshold,
    // gains and fuzzer taps
    input  tx_iq_sample_pkg::bb_gain_t   bb_gain,
    input  tx_iq_sample_pkg::fuzz_gain_t fuzz_gain1,
    input  logic                         fuzz_gain1_rot90,
    input  tx_iq_sample_pkg::fuzz_gain_t fuzz_gain2,
    input  logic                         fuzz_gain2_rot90,
    // host loading and playback
    input  tx_iq_ctrl_pkg::iq_src_e      iq_src,
    input  logic                         host_req,
    input  tx_iq_sample_pkg::iq_pair_t   host_data,
    output logic                         host_ack,
    input  logic                         play_trigger,
    // DAC side, one sample per ready
    input  logic                         dac_ready,
    output tx_iq_sample_pkg::iq_pair_t   dac_iq,
    output logic                         fifo_empty
);

    import tx_iq_sample_pkg::*;

    iq_pair_t scaled_pair;
    logic     scaled_wr;
    iq_pair_t out_pair;   // fifo head or zero

    tx_gain_stage tx_gain_stage_i (
        .clk         (clk),
        .rstn        (rstn),
        .rf_i        (rf_i),
        .rf_q        (rf_q),
        .rf_iq_valid (rf_iq_valid),
        .bb_gain     (bb_gain),
        .tx_hold     (tx_hold),
        .scaled_pair (scaled_pair),
        .scaled_wr   (scaled_wr)
    );

    tx_iq_intf tx_iq_intf_i (
        .clk               (clk),
        .rstn              (rstn),
        .iq_src            (iq_src),
        .scaled_pair       (scaled_pair),
        .scaled_wr         (scaled_wr),
        .host_req          (host_req),
        .host_data         (host_data),
        .host_ack          (host_ack),
        .play_trigger      (play_trigger),
        .dac_ready         (dac_ready),
        .tx_hold_threshold (tx_hold_threshold),
        .tx_hold           (tx_hold),
        .fifo_empty        (fifo_empty),
        .out_pair          (out_pair)
    );

    csi_fuzzer csi_fuzzer_i (
        .clk         (clk),
        .rstn        (rstn),
        .iq          (out_pair),
        .iq_valid    (dac_ready),
        .gain1       (fuzz_gain1),
        .gain1_rot90 (fuzz_gain1_rot90),
        .gain2       (fuzz_gain2),
        .gain2_rot90 (fuzz_gain2_rot90),
        .iq_out      (dac_iq)
    );

endmodule

//--- test/tx_iq_top_properties.sv
// concurrent assertions on the host handshake, fifo fill under hold and the reset state
module tx_iq_top_properties (
    input logic                        clk,
    input logic                        rstn,
    input tx_iq_ctrl_pkg::iq_src_e     iq_src,
    input logic                        host_req,
    input logic                        host_ack,
    input logic                        tx_hold,
    input tx_iq_sample_pkg::fifo_cnt_t tx_hold_threshold,
    input tx_iq_sample_pkg::fifo_cnt_t fifo_count,
    input logic                        fifo_empty,
    input tx_iq_sample_pkg::iq_pair_t  dac_iq
);

    timeunit 1ns;
    timeprecision 100ps;

    import tx_iq_ctrl_pkg::*;

    // ack only ever answers a request
    ack_needs_req: assert property (@(posedge clk) disable iff (!rstn)
        $rose(host_ack) |-> $past(host_req))
        else $error("host_ack rose without host_req");

    ack_drops: assert property (@(posedge clk) disable iff (!rstn)
        (!host_req && $past(!host_req)) |-> !host_ack) // one cycle of turnaround at most
        else $error("host_ack still high two cycles after host_req dropped");

    // a write already in the gain stage still lands after hold rises
    hold_limits_fill: assert property (@(posedge clk) disable iff (!rstn)
        (iq_src == src_core) |-> (fifo_count <= tx_hold_threshold + 2))
        else $error("fifo holds more than threshold+2 samples in core mode");

    // first cycle out of reset
    reset_idle: assert property (@(posedge clk)
        $rose(rstn) |-> (!tx_hold && !host_ack && fifo_empty && dac_iq == '0))
        else $error("outputs not idle in the cycle after reset");

endmodule

bind tx_iq_top tx_iq_top_properties tx_iq_top_properties_i (
    .clk               (clk),
    .rstn              (rstn),
    .iq_src            (iq_src),
    .host_req          (host_req),
    .host_ack          (host_ack),
    .tx_hold           (tx_hold),
    .tx_hold_threshold (tx_hold_threshold),
    .fifo_count        (tx_iq_intf_i.fifo_count),
    .fifo_empty        (fifo_empty),
    .dac_iq            (dac_iq)
);

//--- test/tx_iq_top_tb.sv
// testbench for tx_iq_top: stimulus table, gain and fuzzer reference model, checks, watchdog
`include "tx_iq_config.svh"

module tx_iq_top_tb;

    timeunit 1ns;
    timeprecision 100ps;

    import tx_iq_sample_pkg::*;
    import tx_iq_ctrl_pkg::*;

    localparam int CLK_PERIOD     = 40;
    localparam int DRV_DELAY      = 2;   // after the rising edge
    localparam int CYC_PER_SAMPLE = 12;
    localparam int NUM_ROWS       = 9;

    typedef struct packed {
        iq_src_e    mode;
        bb_gain_t   gain;
        fuzz_gain_t g1;
        logic       r1;
        fuzz_gain_t g2;
        logic       r2;
        fifo_cnt_t  thr;
        int         n;     // samples offered or loaded
        logic       trig;  // play after loading
    } row_t;

    // row 2 runs into the hold, rows 6 to 8 load and play from the host
    row_t rows [NUM_ROWS] = '{
        '{src_core, 10'sd128,  6'sd0,   1'b0, 6'sd0,   1'b0, 10'd500, 8,  1'b0},
        '{src_core, -10'sd300, 6'sd0,   1'b0, 6'sd0,   1'b0, 10'd500, 10, 1'b0},
        '{src_core, 10'sd200,  6'sd0,   1'b0, 6'sd0,   1'b0, 10'd5,   20, 1'b0},
        '{src_core, 10'sd128,  6'sd7,   1'b0, -6'sd5,  1'b0, 10'd500, 10, 1'b0},
        '{src_core, 10'sd150,  -6'sd13, 1'b1, 6'sd9,   1'b0, 10'd500, 10, 1'b0},
        '{src_core, 10'sd100,  6'sd31,  1'b1, -6'sd31, 1'b1, 10'd500, 10, 1'b0},
        '{src_host, 10'sd0,    6'sd0,   1'b0, 6'sd0,   1'b0, 10'd500, 6,  1'b1},
        '{src_host, 10'sd0,    6'sd0,   1'b0, 6'sd0,   1'b0, 10'd500, 4,  1'b0},
        '{src_host, 10'sd0,    6'sd0,   1'b0, 6'sd0,   1'b0, 10'd500, 3,  1'b1}
    };

    logic       clk;
    logic       rstn;
    iq_t        rf_i;
    iq_t        rf_q;
    logic       rf_iq_valid;
    logic       tx_hold;
    fifo_cnt_t  tx_hold_threshold;
    bb_gain_t   bb_gain;
    fuzz_gain_t fuzz_gain1;
    logic       fuzz_gain1_rot90;
    fuzz_gain_t fuzz_gain2;
    logic       fuzz_gain2_rot90;
    iq_src_e    iq_src;
    logic       host_req;
    iq_pair_t   host_data;
    logic       host_ack;
    logic       play_trigger;
    logic       dac_ready;
    iq_pair_t   dac_iq;
    logic       fifo_empty;

    iq_pair_t   exp_q [$];   // fifo contents as the model sees them
    int         m1_i = 0;    // model delay line
    int         m1_q = 0;
    int         m2_i = 0;
    int         m2_q = 0;

    tx_iq_top tx_iq_top_i (.*);

    initial begin
        clk = 1'b0;
        forever #(CLK_PERIOD / 2) clk = ~clk;
    end

    task automatic next_drive;
        @(posedge clk);
        #DRV_DELAY;
    endtask

    task automatic check(input logic [31:0] got, input logic [31:0] exp, input string what);
        if (got !== exp) begin
            $display("Fail at %0t ns: %s is %h, expected %h", $time, what, got, exp);
            $display("Simulation failed");
            $fatal(1);
        end
    endtask

    // gain has 7 fractional bits, result wraps to a component
    function automatic iq_t scale(input iq_t x, input bb_gain_t g);
        int p;
        p = (int'(x) * int'(g)) >>> `TX_GAIN_SHIFT;
        return iq_t'(p);
    endfunction

    function automatic int tap(input fuzz_gain_t g, input int x);
        return (int'(g) * x) >>> `TX_FUZZ_SHIFT;
    endfunction

    // one step per ready pulse, rotation takes (i, q) to (-q, i)
    task automatic fuzz_model(input iq_pair_t cur, output iq_pair_t res);
        int a_i;
        int a_q;
        int b_i;
        int b_q;
        a_i = fuzz_gain1_rot90 ? -m1_q : m1_i;
        a_q = fuzz_gain1_rot90 ? m1_i : m1_q;
        b_i = fuzz_gain2_rot90 ? -m2_q : m2_i;
        b_q = fuzz_gain2_rot90 ? m2_i : m2_q;
        res.i = iq_t'(int'(cur.i) + tap(fuzz_gain1, a_i) + tap(fuzz_gain2, b_i));
        res.q = iq_t'(int'(cur.q) + tap(fuzz_gain1, a_q) + tap(fuzz_gain2, b_q));
        m2_i = m1_i;
        m2_q = m1_q;
        m1_i = cur.i;
        m1_q = cur.q;
    endtask

    // zero is presented when nothing plays
    task automatic pulse_ready(input int pulses, input bit playing);
        iq_pair_t pres;
        iq_pair_t want;
        for (int k = 0; k < pulses; k++) begin
            pres = '0;
            if (playing && exp_q.size() > 0) begin
                pres = exp_q.pop_front();
            end
            next_drive();
            dac_ready = 1'b1;
            next_drive();
            dac_ready = 1'b0;
            fuzz_model(pres, want);
            check(dac_iq, want, "dac_iq");
        end
    endtask

    // core keeps its sample while held, gives up after 4 held cycles
    task automatic offer_core(input int n, output int taken);
        iq_pair_t cur;
        iq_pair_t scaled;
        int       held;
        taken = 0;
        held  = 0;
        cur   = $urandom;
        while (taken < n && held < 4) begin
            next_drive();
            rf_i        = cur.i;
            rf_q        = cur.q;
            rf_iq_valid = 1'b1;
            if (!tx_hold) begin   // taken at the coming edge
                scaled.i = scale(cur.i, bb_gain);
                scaled.q = scale(cur.q, bb_gain);
                exp_q.push_back(scaled);
                taken++;
                held = 0;
                cur  = $urandom;
            end else begin
                held++;
            end
        end
        next_drive();
        rf_iq_valid = 1'b0;
    endtask

    // four-phase write, ack must follow req both ways
    task automatic host_write(input iq_pair_t d);
        int waited;
        waited = 0;
        next_drive();
        check(host_ack, 1'b0, "host_ack before host_req");
        host_data = d;
        host_req  = 1'b1;
        next_drive();
        while (!host_ack && waited < 20) begin
            next_drive();
            waited++;
        end
        check(host_ack, 1'b1, "host_ack while host_req high");
        host_req = 1'b0;
        next_drive();
        check(host_ack, 1'b0, "host_ack after host_req dropped");
        exp_q.push_back(d);
    endtask

    task automatic pulse_trigger;
        next_drive();
        play_trigger = 1'b1;
        next_drive();
        play_trigger = 1'b0;
    endtask

    // budget scales with the samples in the table
    initial begin
        int total;
        total = 0;
        foreach (rows[k]) begin
            total += rows[k].n;
        end
        #(CLK_PERIOD * (total * CYC_PER_SAMPLE + 200));
        $display("Timeout: the run did not finish in the cycle budget for %0d samples", total);
        $display("Simulation failed");
        $fatal(1);
    end

    initial begin
        int taken;
        void'($urandom(40653));
        rstn              = 1'b0;
        rf_i              = '0;
        rf_q              = '0;
        rf_iq_valid       = 1'b0;
        tx_hold_threshold = '0;
        bb_gain           = '0;
        fuzz_gain1        = '0;
        fuzz_gain1_rot90  = 1'b0;
        fuzz_gain2        = '0;
        fuzz_gain2_rot90  = 1'b0;
        iq_src            = src_core;
        host_req          = 1'b0;
        host_data         = '0;
        play_trigger      = 1'b0;
        dac_ready         = 1'b0;
        repeat (3) @(posedge clk);
        #DRV_DELAY;
        rstn = 1'b1;
        check(fifo_empty, 1'b1, "fifo_empty after reset");
        check(tx_hold, 1'b0, "tx_hold after reset");
        check(host_ack, 1'b0, "host_ack after reset");
        check(dac_iq, '0, "dac_iq after reset");

        foreach (rows[r]) begin
            next_drive();
            iq_src            = rows[r].mode;
            bb_gain           = rows[r].gain;
            fuzz_gain1        = rows[r].g1;
            fuzz_gain1_rot90  = rows[r].r1;
            fuzz_gain2        = rows[r].g2;
            fuzz_gain2_rot90  = rows[r].r2;
            tx_hold_threshold = rows[r].thr;
            if (rows[r].mode == src_core) begin
                offer_core(rows[r].n, taken);
                if (rows[r].n > rows[r].thr + 2) begin
                    check(tx_hold, 1'b1, "tx_hold with the fifo above threshold");
                    check(taken >= rows[r].thr + 1 && taken <= rows[r].thr + 2, 1'b1,
                          "samples stored under hold in threshold+1..threshold+2");
                end
                pulse_ready(exp_q.size() + 2, 1'b1); // two extra reads of an empty fifo
                check(fifo_empty, 1'b1, "fifo_empty after drain");
            end else begin
                for (int k = 0; k < rows[r].n; k++) begin
                    host_write($urandom);
                end
                pulse_ready(2, 1'b0);
                check(fifo_empty, 1'b0, "fifo_empty before trigger");
                if (rows[r].trig) begin
                    pulse_trigger();
                    pulse_ready(exp_q.size() + 2, 1'b1);
                    check(fifo_empty, 1'b1, "fifo_empty after playback");
                end
            end
        end

        $display("Simulation passed");
        $finish;
    end

endmodule

//--- tx_iq_top.f
+incdir+verilog
verilog/tx_iq_sample_pkg.sv
verilog/tx_iq_ctrl_pkg.sv
verilog/tx_gain_stage.sv
verilog/tx_iq_fifo.sv
verilog/tx_iq_intf.sv
verilog/csi_fuzzer.sv
verilog/tx_iq_top.sv
test/tx_iq_top_properties.sv
test/tx_iq_top_tb.sv

//--- Bender.yml
package:
  name: tx_iq

export_include_dirs:
  - verilog

sources:
  - files:
      - verilog/tx_iq_sample_pkg.sv
      - verilog/tx_iq_ctrl_pkg.sv
      - verilog/tx_gain_stage.sv
      - verilog/tx_iq_fifo.sv
      - verilog/tx_iq_intf.sv
      - verilog/csi_fuzzer.sv
      - verilog/tx_iq_top.sv
  - target: test
    files:
      - test/tx_iq_top_properties.sv
      - test/tx_iq_top_tb.sv
